//--- dma_rd_consts.svh
// assumes 32-bit data in byte lanes, a power-of-two lane count, descriptors below 8 KB
`ifndef DMA_RD_CONSTS_SVH
`define DMA_RD_CONSTS_SVH

// data path
`define DMA_DATA_W 32
`define DMA_LANES 4
`define DMA_OFFSET_W 2

// descriptor fields
`define DMA_ADDR_W 16
`define DMA_LEN_W 16
`define DMA_TAG_W 8

// beats per AR burst
`define DMA_MAX_BURST_LEN 16
// 13 minus log2 of the lane count
`define DMA_CYCLE_W 11
`define DMA_FIFO_AW 5

`endif

//--- dma_rd_pkg.sv
// shared types of the read DMA; all widths follow the consts header
`include "dma_rd_consts.svh"

package dma_rd_pkg;

    typedef logic [`DMA_ADDR_W-1:0] addr_t;
    typedef logic [`DMA_LEN_W-1:0] len_t;
    typedef logic [`DMA_TAG_W-1:0] tag_t;
    typedef logic [`DMA_DATA_W-1:0] data_t;
    typedef logic [`DMA_LANES-1:0] keep_t;
    typedef logic [`DMA_OFFSET_W-1:0] offset_t;
    typedef logic [`DMA_CYCLE_W-1:0] cycle_t;
    // bytes in one burst, up to a full 4 KB page
    typedef logic [12:0] tr_count_t;

    typedef enum logic [1:0] {
        RESP_OKAY = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

    typedef enum logic [3:0] {
        DMA_ERR_NONE = 4'd0,
        DMA_ERR_RD_SLVERR = 4'd4,
        DMA_ERR_RD_DECERR = 4'd5
    } dma_err_t;

    typedef enum logic [0:0] {BURST_IDLE, BURST_START} burst_state_t;
    typedef enum logic [0:0] {ALIGN_IDLE, ALIGN_READ} align_state_t;

endpackage

//--- dma_rd_if.sv
// links between the DMA blocks; handshake only, both ends share one clock
`timescale 1ns/1ps

interface dma_cmd_if;
    dma_rd_pkg::offset_t offset;
    // bytes in the last stream beat, 0 means all lanes
    dma_rd_pkg::offset_t last_offset;
    dma_rd_pkg::cycle_t in_cycles;
    dma_rd_pkg::cycle_t out_cycles;
    logic bubble;
    dma_rd_pkg::tag_t tag;
    logic valid;
    logic ready;

    modport src (
        output offset, last_offset, in_cycles, out_cycles, bubble, tag, valid,
        input ready
    );
    modport snk (
        input offset, last_offset, in_cycles, out_cycles, bubble, tag, valid,
        output ready
    );
endinterface

interface dma_stream_if;
    dma_rd_pkg::data_t data;
    dma_rd_pkg::keep_t keep;
    logic last;
    logic valid;
    // set at half full
    logic almost_full;

    modport src (output data, keep, last, valid, input almost_full);
    modport snk (input data, keep, last, valid, output almost_full);
endinterface

//--- dma_burst_gen.sv
// one AR in flight at a time; descriptor length must be nonzero and below 8 KB
`timescale 1ns/1ps
`include "dma_rd_consts.svh"

module dma_burst_gen (
    input  logic              clk,
    input  logic              rst,
    input  logic              enable,
    input  dma_rd_pkg::addr_t req_addr,
    input  dma_rd_pkg::len_t  req_len,
    input  dma_rd_pkg::tag_t  req_tag,
    input  logic              req_valid,
    output logic              req_ready,
    output dma_rd_pkg::addr_t araddr,
    output logic [7:0]        arlen,
    output logic              arvalid,
    input  logic              arready,
    dma_cmd_if.src            cmd
);
    localparam int BURST_BYTES = `DMA_MAX_BURST_LEN * `DMA_LANES;

    dma_rd_pkg::burst_state_t state_reg, state_next;
    dma_rd_pkg::addr_t addr_reg, addr_next;
    dma_rd_pkg::len_t count_reg, count_next;
    dma_rd_pkg::offset_t lo;
    dma_rd_pkg::offset_t req_lo;
    dma_rd_pkg::tr_count_t page_ofs;
    dma_rd_pkg::tr_count_t span;
    dma_rd_pkg::tr_count_t tr_count;
    logic req_ready_next;
    logic arvalid_next;
    logic accept;

    assign lo = addr_reg[`DMA_OFFSET_W-1:0];
    assign req_lo = req_addr[`DMA_OFFSET_W-1:0];
    assign page_ofs = {1'b0, addr_reg[11:0]};
    assign accept = req_ready && req_valid;

    // burst size: rest of the transfer, capped at the max burst, cut at the 4 KB page
    always_comb begin
        if (count_reg <= dma_rd_pkg::len_t'(BURST_BYTES) - dma_rd_pkg::len_t'(lo)) begin
            span = dma_rd_pkg::tr_count_t'(count_reg);
        end else begin
            span = dma_rd_pkg::tr_count_t'(BURST_BYTES) - dma_rd_pkg::tr_count_t'(lo);
        end
        if (page_ofs + span > 13'h1000) begin
            tr_count = 13'h1000 - page_ofs;
        end else begin
            tr_count = span;
        end
    end

    always_comb begin
        state_next = state_reg;
        req_ready_next = 1'b0;
        arvalid_next = arvalid && !arready;
        addr_next = addr_reg;
        count_next = count_reg;

        case (state_reg)
            dma_rd_pkg::BURST_IDLE: begin
                req_ready_next = !cmd.valid && enable;
                if (accept) begin
                    addr_next = req_addr;
                    count_next = req_len;
                    req_ready_next = 1'b0;
                    state_next = dma_rd_pkg::BURST_START;
                end
            end
            dma_rd_pkg::BURST_START: begin
                if (!arvalid) begin
                    arvalid_next = 1'b1;
                    addr_next = addr_reg + dma_rd_pkg::addr_t'(tr_count);
                    count_next = count_reg - dma_rd_pkg::len_t'(tr_count);
                    if (count_next == '0) begin
                        req_ready_next = !cmd.valid && enable;
                        state_next = dma_rd_pkg::BURST_IDLE;
                    end
                end
            end
            default: state_next = dma_rd_pkg::BURST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        state_reg <= state_next;
        req_ready <= req_ready_next;
        arvalid <= arvalid_next;
        addr_reg <= addr_next;
        count_reg <= count_next;

        if (state_reg == dma_rd_pkg::BURST_START && !arvalid) begin
            araddr <= addr_reg;
            arlen <= 8'((tr_count + dma_rd_pkg::tr_count_t'(lo) - 13'd1) >> `DMA_OFFSET_W);
        end

        if (cmd.ready) begin
            cmd.valid <= 1'b0;
        end
        // command for the read side; the shift undoes the start misalignment
        if (accept) begin
            cmd.offset <= dma_rd_pkg::offset_t'(`DMA_LANES - int'(req_lo));
            cmd.bubble <= req_lo != '0;
            cmd.last_offset <= req_len[`DMA_OFFSET_W-1:0];
            cmd.in_cycles <= dma_rd_pkg::cycle_t'((req_len + dma_rd_pkg::len_t'(req_lo)
                - dma_rd_pkg::len_t'(1)) >> `DMA_OFFSET_W);
            cmd.out_cycles <= dma_rd_pkg::cycle_t'((req_len - dma_rd_pkg::len_t'(1))
                >> `DMA_OFFSET_W);
            cmd.tag <= req_tag;
            cmd.valid <= 1'b1;
        end

        if (rst) begin
            state_reg <= dma_rd_pkg::BURST_IDLE;
            req_ready <= 1'b0;
            arvalid <= 1'b0;
            cmd.valid <= 1'b0;
        end
    end

endmodule

//--- dma_read_align.sv
// R beats arrive in order at full width; status reports the first bad response of a descriptor
`timescale 1ns/1ps
`include "dma_rd_consts.svh"

module dma_read_align (
    input  logic                   clk,
    input  logic                   rst,
    dma_cmd_if.snk                 cmd,
    input  dma_rd_pkg::data_t      rdata,
    input  dma_rd_pkg::resp_t      rresp,
    input  logic                   rvalid,
    output logic                   rready,
    dma_stream_if.src              out,
    output dma_rd_pkg::tag_t       sts_tag,
    output dma_rd_pkg::dma_err_t   sts_error,
    output logic                   sts_valid
);
    dma_rd_pkg::align_state_t state_reg, state_next;
    dma_rd_pkg::offset_t offset_reg, offset_next;
    dma_rd_pkg::offset_t last_offset_reg, last_offset_next;
    dma_rd_pkg::cycle_t in_count_reg, in_count_next;
    dma_rd_pkg::cycle_t out_count_reg, out_count_next;
    logic in_active_reg, in_active_next;
    logic bubble_reg, bubble_next;
    logic out_last_reg, out_last_next;
    dma_rd_pkg::tag_t tag_reg, tag_next;
    dma_rd_pkg::resp_t err_reg, err_next;
    dma_rd_pkg::tag_t sts_tag_next;
    dma_rd_pkg::dma_err_t sts_error_next;
    logic sts_valid_next;
    logic rready_next;
    logic beat;
    logic save_en;
    dma_rd_pkg::data_t save_reg;
    logic [2*`DMA_DATA_W-1:0] rdata_full;
    dma_rd_pkg::data_t shifted;

    assign beat = rready && rvalid;
    // two beats side by side, the window slides down by the offset
    assign rdata_full = {rdata, save_reg};
    assign shifted = rdata_full[(`DMA_LANES - int'(offset_reg)) * 8 +: `DMA_DATA_W];

    always_comb begin
        state_next = state_reg;
        rready_next = 1'b0;
        save_en = 1'b0;
        cmd.ready = 1'b0;
        offset_next = offset_reg;
        last_offset_next = last_offset_reg;
        in_count_next = in_count_reg;
        out_count_next = out_count_reg;
        in_active_next = in_active_reg;
        bubble_next = bubble_reg;
        out_last_next = out_last_reg;
        tag_next = tag_reg;
        sts_tag_next = sts_tag;
        sts_error_next = sts_error;
        sts_valid_next = 1'b0;
        out.data = shifted;
        out.keep = '1;
        out.last = 1'b0;
        out.valid = 1'b0;

        err_next = err_reg;
        if (beat && err_reg == dma_rd_pkg::RESP_OKAY &&
                (rresp == dma_rd_pkg::RESP_SLVERR || rresp == dma_rd_pkg::RESP_DECERR)) begin
            err_next = rresp;
        end

        case (state_reg)
            dma_rd_pkg::ALIGN_IDLE: begin
                offset_next = cmd.offset;
                last_offset_next = cmd.last_offset;
                in_count_next = cmd.in_cycles;
                out_count_next = cmd.out_cycles;
                bubble_next = cmd.bubble;
                tag_next = cmd.tag;
                out_last_next = cmd.out_cycles == '0;
                in_active_next = 1'b1;
                if (cmd.valid) begin
                    cmd.ready = 1'b1;
                    rready_next = !out.almost_full;
                    state_next = dma_rd_pkg::ALIGN_READ;
                end
            end
            dma_rd_pkg::ALIGN_READ: begin
                rready_next = !out.almost_full && in_active_reg;
                // a flush beat needs no input once the read side is done
                if (beat || !in_active_reg) begin
                    save_en = beat;
                    if (in_active_reg) begin
                        in_count_next = in_count_reg - 1'b1;
                        in_active_next = in_count_reg != '0;
                    end
                    bubble_next = 1'b0;
                    rready_next = !out.almost_full && in_active_next;
                    // the bubble beat only fills the save register
                    if (!bubble_reg) begin
                        out_count_next = out_count_reg - 1'b1;
                        out_last_next = out_count_next == '0;
                        out.valid = 1'b1;
                        if (out_last_reg) begin
                            if (last_offset_reg != '0) begin
                                out.keep = (dma_rd_pkg::keep_t'(1) << last_offset_reg)
                                    - dma_rd_pkg::keep_t'(1);
                            end
                            out.last = 1'b1;
                            sts_tag_next = tag_reg;
                            case (err_next)
                                dma_rd_pkg::RESP_SLVERR:
                                    sts_error_next = dma_rd_pkg::DMA_ERR_RD_SLVERR;
                                dma_rd_pkg::RESP_DECERR:
                                    sts_error_next = dma_rd_pkg::DMA_ERR_RD_DECERR;
                                default:
                                    sts_error_next = dma_rd_pkg::DMA_ERR_NONE;
                            endcase
                            sts_valid_next = 1'b1;
                            err_next = dma_rd_pkg::RESP_OKAY;
                            rready_next = 1'b0;
                            state_next = dma_rd_pkg::ALIGN_IDLE;
                        end
                    end
                end
            end
            default: state_next = dma_rd_pkg::ALIGN_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        state_reg <= state_next;
        rready <= rready_next;
        offset_reg <= offset_next;
        last_offset_reg <= last_offset_next;
        in_count_reg <= in_count_next;
        out_count_reg <= out_count_next;
        in_active_reg <= in_active_next;
        bubble_reg <= bubble_next;
        out_last_reg <= out_last_next;
        tag_reg <= tag_next;
        err_reg <= err_next;
        sts_tag <= sts_tag_next;
        sts_error <= sts_error_next;
        sts_valid <= sts_valid_next;
        if (save_en) begin
            save_reg <= rdata;
        end

        if (rst) begin
            state_reg <= dma_rd_pkg::ALIGN_IDLE;
            rready <= 1'b0;
            err_reg <= dma_rd_pkg::RESP_OKAY;
            sts_error <= dma_rd_pkg::DMA_ERR_NONE;
            sts_valid <= 1'b0;
        end
    end

endmodule

//--- dma_out_fifo.sv
// the writer must hold off at almost_full; a write into a full FIFO is not blocked
`timescale 1ns/1ps
`include "dma_rd_consts.svh"

module dma_out_fifo (
    input  logic              clk,
    input  logic              rst,
    dma_stream_if.snk         in,
    output dma_rd_pkg::data_t tdata,
    output dma_rd_pkg::keep_t tkeep,
    output logic              tlast,
    output logic              tvalid,
    input  logic              tready
);
    localparam int DEPTH = 1 << `DMA_FIFO_AW;

    // pointers carry one wrap bit above the index
    logic [`DMA_FIFO_AW:0] wr_ptr;
    logic [`DMA_FIFO_AW:0] rd_ptr;
    logic [`DMA_FIFO_AW:0] fill;
    logic empty;

    dma_rd_pkg::data_t mem_data [DEPTH];
    dma_rd_pkg::keep_t mem_keep [DEPTH];
    logic mem_last [DEPTH];

    assign empty = wr_ptr == rd_ptr;
    assign fill = wr_ptr - rd_ptr;

    always_ff @(posedge clk) begin
        tvalid <= tvalid && !tready;
        in.almost_full <= fill >= (`DMA_FIFO_AW+1)'(DEPTH / 2);

        if (in.valid) begin
            mem_data[wr_ptr[`DMA_FIFO_AW-1:0]] <= in.data;
            mem_keep[wr_ptr[`DMA_FIFO_AW-1:0]] <= in.keep;
            mem_last[wr_ptr[`DMA_FIFO_AW-1:0]] <= in.last;
            wr_ptr <= wr_ptr + 1'b1;
        end

        // output register refills when it is empty or being drained
        if (!empty && (!tvalid || tready)) begin
            tdata <= mem_data[rd_ptr[`DMA_FIFO_AW-1:0]];
            tkeep <= mem_keep[rd_ptr[`DMA_FIFO_AW-1:0]];
            tlast <= mem_last[rd_ptr[`DMA_FIFO_AW-1:0]];
            tvalid <= 1'b1;
            rd_ptr <= rd_ptr + 1'b1;
        end

        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            tvalid <= 1'b0;
            in.almost_full <= 1'b0;
        end
    end

endmodule

//--- dma_rd_top.sv
// AR is always a full-width INCR burst, so size, burst type and id are not ported
`timescale 1ns/1ps

module dma_rd_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,

    input  dma_rd_pkg::addr_t     req_addr,
    input  dma_rd_pkg::len_t      req_len,
    input  dma_rd_pkg::tag_t      req_tag,
    input  logic                  req_valid,
    output logic                  req_ready,

    output dma_rd_pkg::tag_t      sts_tag,
    output dma_rd_pkg::dma_err_t  sts_error,
    output logic                  sts_valid,

    output dma_rd_pkg::addr_t     araddr,
    output logic [7:0]            arlen,
    output logic                  arvalid,
    input  logic                  arready,

    input  dma_rd_pkg::data_t     rdata,
    input  dma_rd_pkg::resp_t     rresp,
    input  logic                  rvalid,
    output logic                  rready,

    output dma_rd_pkg::data_t     tdata,
    output dma_rd_pkg::keep_t     tkeep,
    output logic                  tlast,
    output logic                  tvalid,
    input  logic                  tready
);
    dma_cmd_if cmd_if ();
    dma_stream_if stream_if ();

    dma_burst_gen dma_burst_gen_inst (
        .clk(clk),
        .rst(rst),
        .enable(enable),
        .req_addr(req_addr),
        .req_len(req_len),
        .req_tag(req_tag),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .araddr(araddr),
        .arlen(arlen),
        .arvalid(arvalid),
        .arready(arready),
        .cmd(cmd_if.src)
    );

    dma_read_align dma_read_align_inst (
        .clk(clk),
        .rst(rst),
        .cmd(cmd_if.snk),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .out(stream_if.src),
        .sts_tag(sts_tag),
        .sts_error(sts_error),
        .sts_valid(sts_valid)
    );

    dma_out_fifo dma_out_fifo_inst (
        .clk(clk),
        .rst(rst),
        .in(stream_if.snk),
        .tdata(tdata),
        .tkeep(tkeep),
        .tlast(tlast),
        .tvalid(tvalid),
        .tready(tready)
    );

endmodule

//--- dma_rd_assert.sv
// checks the AR and stream handshakes of the top level, bound into every dma_rd_top
`timescale 1ns/1ps

module dma_rd_assert (
    input logic              clk,
    input logic              rst,
    input dma_rd_pkg::addr_t araddr,
    input logic [7:0]        arlen,
    input logic              arvalid,
    input logic              arready,
    input dma_rd_pkg::data_t tdata,
    input logic              tvalid,
    input logic              tready
);
    dma_rd_pkg::addr_t ar_end;

    // address of the last byte of the burst
    assign ar_end = {araddr[15:2], 2'b00} + {6'b0, arlen, 2'b11};

    ar_stable_a: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
        else $error("AR request changed before arready");
    t_stable_a: assert property (@(posedge clk) disable iff (rst)
        tvalid && !tready |=> tvalid && $stable(tdata))
        else $error("tvalid or tdata changed before tready");
    ar_page_a: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> ar_end[15:12] == araddr[15:12])
        else $error("AR burst crosses a 4 KB page");
    ar_len_a: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> arlen <= 8'd15)
        else $error("arlen above 15");

endmodule

bind dma_rd_top dma_rd_assert dma_rd_assert_inst (.*);

//--- tb_dma_rd.sv
// memory byte at A is A*7+3 (low byte); run from the project root so the trace file is found
`timescale 1ns/1ps
`include "dma_rd_consts.svh"

module tb_dma_rd;
    localparam int MAX_DESC = 32;

    logic clk = 1'b0;
    logic rst;
    logic enable;
    dma_rd_pkg::addr_t req_addr;
    dma_rd_pkg::len_t req_len;
    dma_rd_pkg::tag_t req_tag;
    logic req_valid;
    logic req_ready;
    dma_rd_pkg::tag_t sts_tag;
    dma_rd_pkg::dma_err_t sts_error;
    logic sts_valid;
    dma_rd_pkg::addr_t araddr;
    logic [7:0] arlen;
    logic arvalid;
    logic arready;
    dma_rd_pkg::data_t rdata;
    dma_rd_pkg::resp_t rresp;
    logic rvalid;
    logic rready;
    dma_rd_pkg::data_t tdata;
    dma_rd_pkg::keep_t tkeep;
    logic tlast;
    logic tvalid;
    logic tready;

    // descriptors as read from the trace
    dma_rd_pkg::addr_t d_addr [MAX_DESC];
    dma_rd_pkg::len_t d_len [MAX_DESC];
    dma_rd_pkg::tag_t d_tag [MAX_DESC];
    logic [3:0] d_err [MAX_DESC];
    logic [3:0] d_stall [MAX_DESC];
    int desc_errors [MAX_DESC];
    int n_desc;

    // memory model, one entry per R beat still to be sent
    dma_rd_pkg::addr_t beat_addr [$];
    dma_rd_pkg::resp_t beat_resp [$];

    int errors, tests_passed, tests_failed, en_before;
    int ar_desc, ar_beats, st_desc, st_byte, sts_desc, req_idx, stall_left;
    int fd, rc, total_bytes, limit, cycles;
    dma_rd_pkg::addr_t ar_next;
    logic r_pend, req_pend, timed_out;
    string line;
    logic [15:0] f_addr, f_len;
    logic [7:0] f_tag;
    logic [3:0] f_err, f_stall;

    always #2 clk = ~clk;

    dma_rd_top dma_rd_top_inst (.*);

    function automatic logic [7:0] mem_byte(input dma_rd_pkg::addr_t a);
        return 8'(a[7:0] * 8'd7 + 8'd3);
    endfunction

    function automatic dma_rd_pkg::data_t beat_data(input dma_rd_pkg::addr_t a);
        dma_rd_pkg::data_t d;
        for (int j = 0; j < `DMA_LANES; j++) begin
            d[8*j +: 8] = mem_byte(a + dma_rd_pkg::addr_t'(j));
        end
        return d;
    endfunction

    // trace codes are rresp values, SLVERR and DECERR map to the read error codes
    function automatic dma_rd_pkg::dma_err_t expected_error(input logic [3:0] code);
        case (code)
            4'd2: return dma_rd_pkg::DMA_ERR_RD_SLVERR;
            4'd3: return dma_rd_pkg::DMA_ERR_RD_DECERR;
            default: return dma_rd_pkg::DMA_ERR_NONE;
        endcase
    endfunction

    function automatic string name_of(input int idx);
        if (idx >= 0) return $sformatf("desc%0d", idx);
        if (idx == -1) return "enable_hold";
        return "run";
    endfunction

    task automatic flag_mismatch(input int idx, input string what, input logic [31:0] exp,
            input logic [31:0] act);
        $display("Error %s %s: expected %h, actual %h", name_of(idx), what, exp, act);
        errors++;
        if (idx >= 0) desc_errors[idx]++;
    endtask

    task automatic note_problem(input int idx, input string msg);
        $display("%s: %s", name_of(idx), msg);
        errors++;
        if (idx >= 0) desc_errors[idx]++;
    endtask

    task automatic take_ar(input dma_rd_pkg::addr_t a, input logic [7:0] l);
        dma_rd_pkg::addr_t first;
        dma_rd_pkg::addr_t last;
        int nb;
        int need;
        first = {a[15:2], 2'b00};
        nb = int'(l) + 1;
        last = first + dma_rd_pkg::addr_t'(4 * nb - 1);
        if (ar_desc >= n_desc) begin
            note_problem(-2, "AR issued after the last descriptor");
            return;
        end
        if (a != ar_next) flag_mismatch(ar_desc, "araddr", 32'(ar_next), 32'(a));
        if (l > 8'd15) flag_mismatch(ar_desc, "arlen limit", 32'd15, 32'(l));
        if (first[15:12] != last[15:12]) note_problem(ar_desc, "AR burst crosses a 4 KB page");
        for (int k = 0; k < nb; k++) begin
            beat_addr.push_back(first + dma_rd_pkg::addr_t'(4 * k));
            // injected error rides on the first beat of the descriptor
            if (ar_beats == 0 && k == 0) begin
                beat_resp.push_back(dma_rd_pkg::resp_t'(d_err[ar_desc][1:0]));
            end else begin
                beat_resp.push_back(dma_rd_pkg::RESP_OKAY);
            end
        end
        ar_beats += nb;
        ar_next = first + dma_rd_pkg::addr_t'(4 * nb);
        need = (int'(d_addr[ar_desc][1:0]) + int'(d_len[ar_desc]) + 3) / 4;
        if (ar_beats >= need) begin
            if (ar_beats != need) flag_mismatch(ar_desc, "AR beats", 32'(need), 32'(ar_beats));
            ar_desc++;
            ar_beats = 0;
            if (ar_desc < n_desc) ar_next = d_addr[ar_desc];
        end
    endtask

    task automatic check_status();
        dma_rd_pkg::dma_err_t err_exp;
        if (sts_desc >= n_desc) begin
            note_problem(-2, "status pulse after the last descriptor");
            return;
        end
        err_exp = expected_error(d_err[sts_desc]);
        if (sts_tag != d_tag[sts_desc]) begin
            flag_mismatch(sts_desc, "sts_tag", 32'(d_tag[sts_desc]), 32'(sts_tag));
        end
        if (sts_error != err_exp) begin
            flag_mismatch(sts_desc, "sts_error", 32'(err_exp), 32'(sts_error));
        end
        sts_desc++;
    endtask

    task automatic check_beat();
        int left;
        logic last_exp;
        dma_rd_pkg::keep_t keep_exp;
        dma_rd_pkg::data_t data_exp;
        dma_rd_pkg::data_t mask;
        if (st_desc >= n_desc) begin
            note_problem(-2, "stream beat after the last descriptor");
            return;
        end
        left = int'(d_len[st_desc]) - st_byte;
        last_exp = left <= `DMA_LANES;
        keep_exp = last_exp ? dma_rd_pkg::keep_t'((1 << left) - 1) : '1;
        for (int j = 0; j < `DMA_LANES; j++) begin
            data_exp[8*j +: 8] = mem_byte(d_addr[st_desc] + dma_rd_pkg::addr_t'(st_byte + j));
            mask[8*j +: 8] = {8{keep_exp[j]}};
        end
        if (tkeep != keep_exp) flag_mismatch(st_desc, "tkeep", 32'(keep_exp), 32'(tkeep));
        if (tlast != last_exp) flag_mismatch(st_desc, "tlast", 32'(last_exp), 32'(tlast));
        if ((tdata & mask) != (data_exp & mask)) begin
            flag_mismatch(st_desc, "tdata", data_exp & mask, tdata & mask);
        end
        st_byte += `DMA_LANES;
        if (last_exp) begin
            if (sts_desc <= st_desc) note_problem(st_desc, "no status pulse before the last beat");
            $display("desc%0d addr %h len %0d tag %h: %s", st_desc, d_addr[st_desc],
                d_len[st_desc], d_tag[st_desc], desc_errors[st_desc] == 0 ? "ok" : "wrong");
            if (desc_errors[st_desc] == 0) tests_passed++;
            else tests_failed++;
            st_desc++;
            st_byte = 0;
        end
    endtask

    initial begin
        void'($urandom(32'h4dea));
        rst = 1'b1;
        enable = 1'b0;
        req_addr = '0;
        req_len = '0;
        req_tag = '0;
        req_valid = 1'b0;
        arready = 1'b1;
        rdata = '0;
        rresp = dma_rd_pkg::RESP_OKAY;
        rvalid = 1'b0;
        tready = 1'b0;
        {errors, tests_passed, tests_failed, cycles, total_bytes, n_desc} = '0;
        {ar_desc, ar_beats, st_desc, st_byte, sts_desc, req_idx, stall_left} = '0;
        {r_pend, req_pend, timed_out} = '0;

        fd = $fopen("dma_rd_trace.txt", "r");
        if (fd == 0) begin
            note_problem(-2, "cannot open dma_rd_trace.txt");
        end else begin
            while (!$feof(fd) && n_desc < MAX_DESC) begin
                line = "";
                rc = $fgets(line, fd);
                if (rc != 0 && line.len() > 4 && line.substr(0, 1) != "//") begin
                    rc = $sscanf(line, "%h %h %h %h %h", f_addr, f_len, f_tag, f_err, f_stall);
                    if (rc == 5) begin
                        d_addr[n_desc] = f_addr;
                        d_len[n_desc] = f_len;
                        d_tag[n_desc] = f_tag;
                        d_err[n_desc] = f_err;
                        d_stall[n_desc] = f_stall;
                        desc_errors[n_desc] = 0;
                        total_bytes += int'(f_len);
                        n_desc++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_desc == 0) note_problem(-2, "no descriptors in the trace");
        limit = 200 + 4 * total_bytes;
        if (n_desc > 0) ar_next = d_addr[0];

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // first descriptor is held while the engine is disabled
        en_before = errors;
        if (n_desc > 0) begin
            req_addr = d_addr[0];
            req_len = d_len[0];
            req_tag = d_tag[0];
            req_valid = 1'b1;
        end
        repeat (20) begin
            @(negedge clk);
            cycles++;
            if (req_ready) note_problem(-1, "req_ready went high while enable was low");
            if (arvalid) note_problem(-1, "AR issued while enable was low");
        end
        $display("enable_hold: %s", errors == en_before ? "ok" : "wrong");
        if (errors == en_before) tests_passed++;
        else tests_failed++;
        enable = 1'b1;

        while (st_desc < n_desc || sts_desc < n_desc) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                timed_out = 1'b1;
                break;
            end
            if (sts_valid) check_status();
            if (arvalid && arready) take_ar(araddr, arlen);

            if (r_pend) begin
                void'(beat_addr.pop_front());
                void'(beat_resp.pop_front());
                rvalid = 1'b0;
            end
            if (!rvalid && beat_addr.size() > 0 && $urandom_range(3, 0) != 0) begin
                rdata = beat_data(beat_addr[0]);
                rresp = beat_resp[0];
                rvalid = 1'b1;
            end
            r_pend = rvalid && rready;

            if (st_desc < n_desc && d_stall[st_desc] != 0) begin
                // long stalls fill the FIFO past half so rready gets throttled
                if (stall_left > 0) begin
                    tready = 1'b0;
                    stall_left--;
                end else begin
                    tready = 1'b1;
                    if ($urandom_range(3, 0) == 0) stall_left = $urandom_range(40, 8);
                end
            end else begin
                tready = $urandom_range(7, 0) != 0;
            end
            if (tvalid && tready) check_beat();

            if (req_pend) req_idx++;
            if (req_idx < n_desc) begin
                req_addr = d_addr[req_idx];
                req_len = d_len[req_idx];
                req_tag = d_tag[req_idx];
                req_valid = 1'b1;
            end else begin
                req_valid = 1'b0;
            end
            req_pend = req_valid && req_ready;
        end

        if (timed_out) begin
            $display("timeout after %0d cycles with %0d of %0d descriptors done",
                cycles, st_desc, n_desc);
            tests_failed += n_desc - st_desc;
        end else begin
            repeat (10) begin
                @(negedge clk);
                if (sts_valid || tvalid || arvalid) begin
                    note_problem(-2, "DUT still active after the last descriptor");
                end
            end
            if (beat_addr.size() != 0) note_problem(-2, "R beats left that were never read");
        end

        $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- dma_rd_trace.txt
// one descriptor per line, all hex: address length tag error stall
// error 2 injects SLVERR and 3 DECERR on the first beat; stall 1 holds tready low in long runs
0000 0004 01 0 0
0040 0040 02 0 0
0200 00c8 03 0 0
0103 000d 04 0 0
0105 0007 05 2 0
0301 0001 06 0 0
0ff0 0040 07 0 0
1ffe 0050 08 3 0
0422 0100 09 0 1
0500 0003 0a 0 0
0607 0045 0b 0 1
07fd 0002 0c 2 1
0a00 0081 0d 0 0
0c3e 0022 0e 0 0
0f81 0090 0f 0 1

//--- vlog.f
+incdir+.
dma_rd_pkg.sv
dma_rd_if.sv
dma_burst_gen.sv
dma_read_align.sv
dma_out_fifo.sv
dma_rd_top.sv
dma_rd_assert.sv
tb_dma_rd.sv

//--- Makefile
LOG := sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_dma_rd -o tb_dma_rd
	./obj_dir/tb_dma_rd | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
